// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// Field widths
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;
	localparam int INDEX_W    = 26;
	localparam int REG_COUNT  = 32;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT_W-1:0]    funct_t;

	//////////////////////////////////////////////////
	// Primary opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;

	// SPECIAL function field
	localparam funct_t FN_JR   = 6'b001000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;

	localparam reg_addr_t LINK_REG   = 5'd31;
	localparam word_t     INST_BYTES = 32'd4;

endpackage

`default_nettype wire

// File: id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

	// Unit class seen by execute
	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_ARITH,
		SEL_MEM,
		SEL_BRANCH
	} alu_sel_e;

	typedef enum logic [4:0] {
		OP_NOP,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADDU,
		ALU_SUBU,
		ALU_SLT,
		ALU_JR,
		ALU_ORI,
		ALU_ANDI,
		ALU_XORI,
		ALU_LUI,
		ALU_ADDIU,
		ALU_SLTI,
		ALU_LW,
		ALU_SW,
		ALU_BEQ,
		ALU_BNE,
		ALU_J,
		ALU_JAL
	} alu_op_e;

	// MIPS cause register encoding
	typedef enum logic [4:0] {
		EC_NONE = 5'd0,
		EC_RI   = 5'd10
	} exc_code_e;

	//////////////////////////////////////////////////
	// Bubble
	localparam alu_sel_e  BUBBLE_SEL = SEL_NOP;
	localparam alu_op_e   BUBBLE_OP  = OP_NOP;
	localparam logic      BUBBLE_WE  = 1'b0;
	localparam exc_code_e BUBBLE_EXC = EC_NONE;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
	import mips_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [REG_COUNT];

	// Register 0 is hardwired, write is visible in the same cycle
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (we_i && (waddr_i == addr))
			return wdata_i;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  word_t     inst_i,
	output alu_sel_e  alu_sel_o,
	output alu_op_e   alu_op_o,
	output logic      re1_o,
	output logic      re2_o,
	output reg_addr_t raddr1_o,
	output reg_addr_t raddr2_o,
	output logic      we_o,
	output reg_addr_t waddr_o,
	output word_t     imm_o,
	output logic      reserved_o
);

	opcode_t          op;
	funct_t           fn;
	reg_addr_t        rs;
	reg_addr_t        rt;
	reg_addr_t        rd;
	reg_addr_t        sa;
	logic [IMM_W-1:0] imm16;
	word_t            zero_imm;
	word_t            sign_imm;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign fn    = inst_i[5:0];
	assign imm16 = inst_i[IMM_W-1:0];

	assign zero_imm = {{(WORD_W-IMM_W){1'b0}}, imm16};
	assign sign_imm = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};

	always_comb begin
		alu_sel_o  = BUBBLE_SEL;
		alu_op_o   = BUBBLE_OP;
		re1_o      = 1'b0;
		re2_o      = 1'b0;
		raddr1_o   = rs;
		raddr2_o   = rt;
		we_o       = BUBBLE_WE;
		waddr_o    = rd;
		imm_o      = '0;
		reserved_o = 1'b0;

		case (op)
			OP_SPECIAL: begin
				re1_o = 1'b1;
				re2_o = 1'b1;
				we_o  = 1'b1;
				case (fn)
					FN_AND:  {alu_sel_o, alu_op_o} = {SEL_LOGIC, ALU_AND};
					FN_OR:   {alu_sel_o, alu_op_o} = {SEL_LOGIC, ALU_OR};
					FN_XOR:  {alu_sel_o, alu_op_o} = {SEL_LOGIC, ALU_XOR};
					FN_NOR:  {alu_sel_o, alu_op_o} = {SEL_LOGIC, ALU_NOR};
					FN_ADDU: {alu_sel_o, alu_op_o} = {SEL_ARITH, ALU_ADDU};
					FN_SUBU: {alu_sel_o, alu_op_o} = {SEL_ARITH, ALU_SUBU};
					FN_SLT:  {alu_sel_o, alu_op_o} = {SEL_ARITH, ALU_SLT};
					FN_JR: begin
						alu_sel_o = SEL_BRANCH;
						alu_op_o  = ALU_JR;
						re2_o     = 1'b0;
						we_o      = 1'b0;
					end
					default: reserved_o = 1'b1;
				endcase
				// No shifts are kept, so sa must be zero
				if (sa != '0)
					reserved_o = 1'b1;
			end

			OP_ORI, OP_ANDI, OP_XORI: begin
				alu_sel_o = SEL_LOGIC;
				case (op)
					OP_ORI:  alu_op_o = ALU_ORI;
					OP_ANDI: alu_op_o = ALU_ANDI;
					default: alu_op_o = ALU_XORI;
				endcase
				re1_o   = 1'b1;
				we_o    = 1'b1;
				waddr_o = rt;
				imm_o   = zero_imm;
			end

			OP_LUI: begin
				alu_sel_o  = SEL_LOGIC;
				alu_op_o   = ALU_LUI;
				we_o       = 1'b1;
				waddr_o    = rt;
				imm_o      = zero_imm;
				reserved_o = (rs != '0);
			end

			OP_ADDIU, OP_SLTI: begin
				alu_sel_o = SEL_ARITH;
				alu_op_o  = (op == OP_ADDIU) ? ALU_ADDIU : ALU_SLTI;
				re1_o     = 1'b1;
				we_o      = 1'b1;
				waddr_o   = rt;
				imm_o     = sign_imm;
			end

			OP_LW: begin
				alu_sel_o = SEL_MEM;
				alu_op_o  = ALU_LW;
				re1_o     = 1'b1;
				we_o      = 1'b1;
				waddr_o   = rt;
				imm_o     = sign_imm;
			end

			OP_SW: begin
				alu_sel_o = SEL_MEM;
				alu_op_o  = ALU_SW;
				re1_o     = 1'b1;
				re2_o     = 1'b1;
				imm_o     = sign_imm;
			end

			OP_BEQ, OP_BNE: begin
				alu_sel_o = SEL_BRANCH;
				alu_op_o  = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				re1_o     = 1'b1;
				re2_o     = 1'b1;
			end

			OP_J: begin
				alu_sel_o = SEL_BRANCH;
				alu_op_o  = ALU_J;
			end

			OP_JAL: begin
				alu_sel_o = SEL_BRANCH;
				alu_op_o  = ALU_JAL;
				we_o      = 1'b1;
				waddr_o   = LINK_REG;
			end

			default: reserved_o = 1'b1;
		endcase

		// Reserved encodings decode as a bubble
		if (reserved_o) begin
			alu_sel_o = BUBBLE_SEL;
			alu_op_o  = BUBBLE_OP;
			re1_o     = 1'b0;
			re2_o     = 1'b0;
			we_o      = BUBBLE_WE;
			imm_o     = '0;
		end
	end

endmodule

`default_nettype wire

// File: operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward
	import mips_isa_pkg::*;
(
	input  logic      re1_i,
	input  logic      re2_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	input  word_t     rdata1_i,
	input  word_t     rdata2_i,
	input  word_t     imm_i,
	input  logic      ex_we_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_wdata_i,
	input  logic      ex_mem_op_i,
	input  logic      mem_we_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_wdata_i,
	output word_t     src1_o,
	output word_t     src2_o,
	output logic      stall_o
);

	// Newest result wins, register 0 never forwards
	function automatic word_t pick(input logic re, input reg_addr_t addr, input word_t rdata);
		if (!re)
			return imm_i;
		else if (addr == '0)
			return '0;
		else if (ex_we_i && (ex_waddr_i == addr))
			return ex_wdata_i;
		else if (mem_we_i && (mem_waddr_i == addr))
			return mem_wdata_i;
		else
			return rdata;
	endfunction

	always_comb begin
		src1_o = pick(re1_i, raddr1_i, rdata1_i);
		src2_o = pick(re2_i, raddr2_i, rdata2_i);
	end

	// Load or store in execute, its data is not ready yet
	assign stall_o = ex_mem_op_i;

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  word_t   pc_i,
	input  word_t   inst_i,
	input  alu_op_e alu_op_i,
	input  word_t   src1_i,
	input  word_t   src2_i,
	input  logic    hold_i,
	output logic    taken_o,
	output word_t   target_o,
	output word_t   link_addr_o,
	output logic    is_branch_o
);

	word_t pc_plus4;
	word_t br_target;
	word_t jmp_target;
	logic  cond;

	assign pc_plus4    = pc_i + INST_BYTES;
	assign link_addr_o = pc_plus4 + INST_BYTES;

	assign br_target  = pc_plus4 +
		{{(WORD_W-IMM_W-2){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0], 2'b00};
	assign jmp_target = {pc_plus4[31:28], inst_i[INDEX_W-1:0], 2'b00};

	always_comb begin
		cond        = 1'b0;
		target_o    = '0;
		is_branch_o = 1'b1;
		case (alu_op_i)
			ALU_BEQ: begin
				cond     = (src1_i == src2_i);
				target_o = br_target;
			end
			ALU_BNE: begin
				cond     = (src1_i != src2_i);
				target_o = br_target;
			end
			ALU_J, ALU_JAL: begin
				cond     = 1'b1;
				target_o = jmp_target;
			end
			ALU_JR: begin
				cond     = 1'b1;
				target_o = src1_i;
			end
			default: is_branch_o = 1'b0;
		endcase
	end

	// Held instruction is redecoded next cycle
	assign taken_o = cond && !hold_i;

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  logic      wb_we_i,
	input  reg_addr_t wb_addr_i,
	input  word_t     wb_data_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_we_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_wdata_i,
	output logic      stall_o,
	output logic      branch_taken_o,
	output word_t     branch_addr_o,
	output alu_sel_e  ex_alu_sel_o,
	output alu_op_e   ex_alu_op_o,
	output word_t     ex_src1_o,
	output word_t     ex_src2_o,
	output logic      ex_we_o,
	output reg_addr_t ex_waddr_o,
	output word_t     ex_link_addr_o,
	output word_t     ex_inst_o,
	output logic      ex_in_delay_o,
	output exc_code_e ex_exc_code_o,
	output word_t     ex_exc_epc_o
);

	alu_sel_e  dec_sel;
	alu_op_e   dec_op;
	logic      dec_re1;
	logic      dec_re2;
	reg_addr_t dec_raddr1;
	reg_addr_t dec_raddr2;
	logic      dec_we;
	reg_addr_t dec_waddr;
	word_t     dec_imm;
	logic      dec_reserved;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	word_t     src1;
	word_t     src2;
	word_t     link_addr;
	logic      is_branch;
	logic      ex_mem_op;
	logic      in_delay_q;

	assign ex_mem_op = (ex_alu_sel_o == SEL_MEM);

	reg_file i_reg_file (
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (wb_we_i),
		.waddr_i  (wb_addr_i),
		.wdata_i  (wb_data_i),
		.raddr1_i (dec_raddr1),
		.raddr2_i (dec_raddr2),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2)
	);

	inst_decoder i_inst_decoder (
		.inst_i     (inst_i),
		.alu_sel_o  (dec_sel),
		.alu_op_o   (dec_op),
		.re1_o      (dec_re1),
		.re2_o      (dec_re2),
		.raddr1_o   (dec_raddr1),
		.raddr2_o   (dec_raddr2),
		.we_o       (dec_we),
		.waddr_o    (dec_waddr),
		.imm_o      (dec_imm),
		.reserved_o (dec_reserved)
	);

	operand_forward i_operand_forward (
		.re1_i       (dec_re1),
		.re2_i       (dec_re2),
		.raddr1_i    (dec_raddr1),
		.raddr2_i    (dec_raddr2),
		.rdata1_i    (rf_rdata1),
		.rdata2_i    (rf_rdata2),
		.imm_i       (dec_imm),
		.ex_we_i     (ex_we_o),
		.ex_waddr_i  (ex_waddr_o),
		.ex_wdata_i  (ex_wdata_i),
		.ex_mem_op_i (ex_mem_op),
		.mem_we_i    (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.src1_o      (src1),
		.src2_o      (src2),
		.stall_o     (stall_o)
	);

	branch_unit i_branch_unit (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.alu_op_i    (dec_op),
		.src1_i      (src1),
		.src2_i      (src2),
		.hold_i      (stall_o),
		.taken_o     (branch_taken_o),
		.target_o    (branch_addr_o),
		.link_addr_o (link_addr),
		.is_branch_o (is_branch)
	);

	//////////////////////////////////////////////////
	// Delay slot tracking for the instruction in decode
	always_ff @(posedge clk) begin
		if (rst_i)
			in_delay_q <= 1'b0;
		else if (!stall_o)
			in_delay_q <= is_branch;
	end

	//////////////////////////////////////////////////
	// ID/EX control
	always_ff @(posedge clk) begin
		if (rst_i || stall_o) begin
			ex_alu_sel_o  <= BUBBLE_SEL;
			ex_alu_op_o   <= BUBBLE_OP;
			ex_we_o       <= BUBBLE_WE;
			ex_in_delay_o <= 1'b0;
			ex_exc_code_o <= BUBBLE_EXC;
		end else begin
			ex_alu_sel_o  <= dec_sel;
			ex_alu_op_o   <= dec_op;
			ex_we_o       <= dec_we && !dec_reserved;
			ex_in_delay_o <= in_delay_q;
			ex_exc_code_o <= dec_reserved ? EC_RI : EC_NONE;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		ex_src1_o      <= src1;
		ex_src2_o      <= src2;
		ex_waddr_o     <= dec_waddr;
		ex_link_addr_o <= link_addr;
		ex_inst_o      <= inst_i;
		// EPC points back at the branch for a delay slot
		ex_exc_epc_o   <= in_delay_q ? (pc_i - INST_BYTES) : pc_i;
	end

endmodule

`default_nettype wire

// File: id_stage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_assert
	import id_ctrl_pkg::*;
(
	input logic      clk,
	input logic      rst_i,
	input logic      stall_i,
	input logic      taken_i,
	input logic      we_i,
	input exc_code_e exc_code_i
);

	int fail_count = 0;

	// A memory stall lasts exactly one cycle
	assert property (@(posedge clk) disable iff (rst_i) stall_i |=> !stall_i)
		else begin
			fail_count++;
			$error("stall_o high for two cycles in a row");
		end

	assert property (@(posedge clk) disable iff (rst_i) stall_i |-> !taken_i)
		else begin
			fail_count++;
			$error("branch_taken_o high while stall_o is high");
		end

	// Excepting instructions never write
	assert property (@(posedge clk) disable iff (rst_i) (exc_code_i != EC_NONE) |-> !we_i)
		else begin
			fail_count++;
			$error("ex_we_o high with an exception code set");
		end

endmodule

bind id_stage id_stage_assert i_id_stage_assert (
	.clk        (clk),
	.rst_i      (rst_i),
	.stall_i    (stall_o),
	.taken_i    (branch_taken_o),
	.we_i       (ex_we_o),
	.exc_code_i (ex_exc_code_o)
);

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
;

	localparam int  RESET_CYCLES = 10;
	localparam real SETTLE       = 2.5;

	typedef struct {
		string     name;
		word_t     pc;
		word_t     inst;
		word_t     ex_wdata;
		logic      mem_we;
		reg_addr_t mem_waddr;
		word_t     mem_wdata;
		logic      wb_we;
		reg_addr_t wb_addr;
		word_t     wb_data;
		int        stall;
		logic      taken;
		word_t     target;
		alu_sel_e  sel;
		alu_op_e   op;
		word_t     src1;
		word_t     src2;
		logic      we;
		reg_addr_t waddr;
		logic      delay;
		exc_code_e exc;
	} row_t;

	logic      clk;
	logic      rst_i;
	word_t     pc_i;
	word_t     inst_i;
	logic      wb_we_i;
	reg_addr_t wb_addr_i;
	word_t     wb_data_i;
	word_t     ex_wdata_i;
	logic      mem_we_i;
	reg_addr_t mem_waddr_i;
	word_t     mem_wdata_i;
	logic      stall_o;
	logic      branch_taken_o;
	word_t     branch_addr_o;
	alu_sel_e  ex_alu_sel_o;
	alu_op_e   ex_alu_op_o;
	word_t     ex_src1_o;
	word_t     ex_src2_o;
	logic      ex_we_o;
	reg_addr_t ex_waddr_o;
	word_t     ex_link_addr_o;
	word_t     ex_inst_o;
	logic      ex_in_delay_o;
	exc_code_e ex_exc_code_o;
	word_t     ex_exc_epc_o;

	row_t      rows [$];
	word_t     rf [REG_COUNT];
	word_t     pc;
	word_t     fwd_exw;
	logic      fwd_mwe;
	reg_addr_t fwd_mwa;
	word_t     fwd_mwd;
	logic      fwd_wwe;
	reg_addr_t fwd_wwa;
	word_t     fwd_wwd;
	int        seed;
	int        checks;
	int        errors;
	logic      table_ready;

	id_stage i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Instruction encoders
	function automatic word_t r_inst(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_inst(opcode_t op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_inst(opcode_t op, logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic check_equal(input string test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch in %s (%s): expected %h, actual %h", test, field, exp, act);
		end
	endtask

	// Forwarding inputs for the next row only
	task automatic set_fwd(input word_t exw, input logic mwe, input reg_addr_t mwa,
		input word_t mwd);
		fwd_exw = exw;
		fwd_mwe = mwe;
		fwd_mwa = mwa;
		fwd_mwd = mwd;
	endtask

	// Write-back inputs for the next row only
	task automatic set_wb(input logic we, input reg_addr_t addr, input word_t data);
		fwd_wwe = we;
		fwd_wwa = addr;
		fwd_wwd = data;
	endtask

	task automatic add_row(input string name, input word_t inst, input int stall,
		input logic taken, input word_t target, input alu_sel_e sel, input alu_op_e op,
		input word_t src1, input word_t src2, input logic we, input reg_addr_t waddr,
		input logic delay, input exc_code_e exc);
		rows.push_back('{name, pc, inst, fwd_exw, fwd_mwe, fwd_mwa, fwd_mwd,
			fwd_wwe, fwd_wwa, fwd_wwd, stall, taken,
			target, sel, op, src1, src2, we, waddr, delay, exc});
		pc = pc + INST_BYTES;
		set_fwd(32'hE0E0_E0E0, 1'b0, 5'd0, 32'h0);
		set_wb(1'b0, 5'd0, 32'h0);
	endtask

	task automatic build_table();
		pc = 32'h0040_0000;
		set_fwd(32'hE0E0_E0E0, 1'b0, 5'd0, 32'h0);
		set_wb(1'b0, 5'd0, 32'h0);
		add_row("and", r_inst(FN_AND, 1, 2, 10), 0, 0, '0,
			SEL_LOGIC, ALU_AND, rf[1], rf[2], 1, 10, 0, EC_NONE);
		add_row("addu", r_inst(FN_ADDU, 3, 4, 11), 0, 0, '0,
			SEL_ARITH, ALU_ADDU, rf[3], rf[4], 1, 11, 0, EC_NONE);
		add_row("ori", i_inst(OP_ORI, 7, 13, 16'h8001), 0, 0, '0,
			SEL_LOGIC, ALU_ORI, rf[7], 32'h0000_8001, 1, 13, 0, EC_NONE);
		add_row("addiu", i_inst(OP_ADDIU, 8, 14, 16'hFFF0), 0, 0, '0,
			SEL_ARITH, ALU_ADDIU, rf[8], 32'hFFFF_FFF0, 1, 14, 0, EC_NONE);
		add_row("subu", r_inst(FN_SUBU, 5, 6, 21), 0, 0, '0,
			SEL_ARITH, ALU_SUBU, rf[5], rf[6], 1, 21, 0, EC_NONE);
		add_row("slt", r_inst(FN_SLT, 9, 10, 22), 0, 0, '0,
			SEL_ARITH, ALU_SLT, rf[9], rf[10], 1, 22, 0, EC_NONE);
		add_row("xori", i_inst(OP_XORI, 11, 12, 16'h8000), 0, 0, '0,
			SEL_LOGIC, ALU_XORI, rf[11], 32'h0000_8000, 1, 12, 0, EC_NONE);
		// Write-back to r28 in the same cycle reaches the read port
		set_wb(1'b1, 28, 32'h1357_9BDF);
		add_row("wb_through", r_inst(FN_ADDU, 28, 2, 3), 0, 0, '0,
			SEL_ARITH, ALU_ADDU, 32'h1357_9BDF, rf[2], 1, 3, 0, EC_NONE);
		add_row("lui", i_inst(OP_LUI, 0, 15, 16'h1234), 0, 0, '0,
			SEL_LOGIC, ALU_LUI, 32'h0000_1234, 32'h0000_1234, 1, 15, 0, EC_NONE);
		// Execute beats memory on r15
		set_fwd(32'hA5A5_0001, 1'b1, 15, 32'h5A5A_0002);
		add_row("fwd_ex", r_inst(FN_OR, 15, 9, 16), 0, 0, '0,
			SEL_LOGIC, ALU_OR, 32'hA5A5_0001, rf[9], 1, 16, 0, EC_NONE);
		set_fwd(32'hC3C3_0003, 1'b1, 17, 32'h3C3C_0004);
		add_row("fwd_mem", r_inst(FN_XOR, 17, 16, 18), 0, 0, '0,
			SEL_LOGIC, ALU_XOR, 32'h3C3C_0004, 32'hC3C3_0003, 1, 18, 0, EC_NONE);
		add_row("addu_r0", r_inst(FN_ADDU, 1, 2, 0), 0, 0, '0,
			SEL_ARITH, ALU_ADDU, rf[1], rf[2], 1, 0, 0, EC_NONE);
		set_fwd(32'h7777_7777, 1'b1, 0, 32'h8888_8888);
		add_row("fwd_r0", r_inst(FN_NOR, 0, 0, 19), 0, 0, '0,
			SEL_LOGIC, ALU_NOR, 32'h0, 32'h0, 1, 19, 0, EC_NONE);
		add_row("beq_taken", i_inst(OP_BEQ, 4, 4, 16'h0010), 0, 1, pc + 32'd4 + 32'h40,
			SEL_BRANCH, ALU_BEQ, rf[4], rf[4], 0, 0, 0, EC_NONE);
		add_row("slot_and", r_inst(FN_AND, 23, 24, 25), 0, 0, '0,
			SEL_LOGIC, ALU_AND, rf[23], rf[24], 1, 25, 1, EC_NONE);
		add_row("bne", i_inst(OP_BNE, 5, 6, 16'hFFFC), 0, rf[5] != rf[6], pc + 32'd4 - 32'd16,
			SEL_BRANCH, ALU_BNE, rf[5], rf[6], 0, 0, 0, EC_NONE);
		add_row("slot_andi", i_inst(OP_ANDI, 26, 27, 16'hF00F), 0, 0, '0,
			SEL_LOGIC, ALU_ANDI, rf[26], 32'h0000_F00F, 1, 27, 1, EC_NONE);
		// Whole table sits in the lowest 256 MB region
		add_row("j", j_inst(OP_J, 26'h0100040), 0, 1, {4'h0, 26'h0100040, 2'b00},
			SEL_BRANCH, ALU_J, 32'h0, 32'h0, 0, 0, 0, EC_NONE);
		add_row("slot_slti", i_inst(OP_SLTI, 7, 29, 16'h8000), 0, 0, '0,
			SEL_ARITH, ALU_SLTI, rf[7], 32'hFFFF_8000, 1, 29, 1, EC_NONE);
		add_row("jal", j_inst(OP_JAL, 26'h0200000), 0, 1, 32'h0080_0000,
			SEL_BRANCH, ALU_JAL, 32'h0, 32'h0, 1, LINK_REG, 0, EC_NONE);
		// Link value comes back through execute forwarding
		set_fwd(32'h0040_1000, 1'b0, 0, 32'h0);
		add_row("jr", r_inst(FN_JR, LINK_REG, 0, 0), 0, 1, 32'h0040_1000,
			SEL_BRANCH, ALU_JR, 32'h0040_1000, 32'h0, 0, 0, 1, EC_NONE);
		add_row("rsvd_delay", 32'hFC00_0000, 0, 0, '0,
			SEL_NOP, OP_NOP, 32'h0, 32'h0, 0, 0, 1, EC_RI);
		add_row("lw", i_inst(OP_LW, 1, 30, 16'h0008), 0, 0, '0,
			SEL_MEM, ALU_LW, rf[1], 32'h0000_0008, 1, 30, 0, EC_NONE);
		add_row("after_lw", r_inst(FN_ADDU, 2, 3, 20), 1, 0, '0,
			SEL_ARITH, ALU_ADDU, rf[2], rf[3], 1, 20, 0, EC_NONE);
		add_row("sw", i_inst(OP_SW, 4, 5, 16'hFFFC), 0, 0, '0,
			SEL_MEM, ALU_SW, rf[4], rf[5], 0, 0, 0, EC_NONE);
		add_row("beq_stall", i_inst(OP_BEQ, 6, 6, 16'h0008), 1, 1, pc + 32'd4 + 32'h20,
			SEL_BRANCH, ALU_BEQ, rf[6], rf[6], 0, 0, 0, EC_NONE);
		add_row("rsvd_sa", r_inst(FN_AND, 1, 2, 3) | 32'h40, 0, 0, '0,
			SEL_NOP, OP_NOP, 32'h0, 32'h0, 0, 0, 1, EC_RI);
		add_row("rsvd_lui", i_inst(OP_LUI, 3, 4, 16'h0001), 0, 0, '0,
			SEL_NOP, OP_NOP, 32'h0, 32'h0, 0, 0, 0, EC_RI);
		add_row("rsvd_fn", r_inst(6'h00, 1, 2, 3), 0, 0, '0,
			SEL_NOP, OP_NOP, 32'h0, 32'h0, 0, 0, 0, EC_RI);
		// Branches that fall through still open a delay slot
		add_row("beq_not", i_inst(OP_BEQ, 5, 6, 16'h0004), 0, rf[5] == rf[6],
			pc + 32'd4 + 32'h10, SEL_BRANCH, ALU_BEQ, rf[5], rf[6], 0, 0, 0, EC_NONE);
		add_row("bne_not", i_inst(OP_BNE, 4, 4, 16'h0004), 0, 0,
			pc + 32'd4 + 32'h10, SEL_BRANCH, ALU_BNE, rf[4], rf[4], 0, 0, 1, EC_NONE);
	endtask

	//////////////////////////////////////////////////
	// Runs one row from falling edge to falling edge
	task automatic apply_row(input row_t r);
		int    stalls;
		word_t epc;
		pc_i        = r.pc;
		inst_i      = r.inst;
		ex_wdata_i  = r.ex_wdata;
		mem_we_i    = r.mem_we;
		mem_waddr_i = r.mem_waddr;
		mem_wdata_i = r.mem_wdata;
		wb_we_i     = r.wb_we;
		wb_addr_i   = r.wb_addr;
		wb_data_i   = r.wb_data;
		#(SETTLE);
		stalls = 0;
		while (stall_o && stalls < 3) begin
			check_equal(r.name, "taken under stall", 0, branch_taken_o);
			@(posedge clk);
			@(negedge clk);
			check_equal(r.name, "bubble class", SEL_NOP, ex_alu_sel_o);
			check_equal(r.name, "bubble write", 0, ex_we_o);
			stalls++;
			#(SETTLE);
		end
		check_equal(r.name, "stall cycles", r.stall, stalls);
		check_equal(r.name, "branch taken", r.taken, branch_taken_o);
		if (r.taken)
			check_equal(r.name, "branch target", r.target, branch_addr_o);
		@(posedge clk);
		@(negedge clk);
		epc = r.delay ? (r.pc - INST_BYTES) : r.pc;
		check_equal(r.name, "unit class", r.sel, ex_alu_sel_o);
		check_equal(r.name, "operation", r.op, ex_alu_op_o);
		check_equal(r.name, "src1", r.src1, ex_src1_o);
		check_equal(r.name, "src2", r.src2, ex_src2_o);
		check_equal(r.name, "write enable", r.we, ex_we_o);
		if (r.we)
			check_equal(r.name, "destination", r.waddr, ex_waddr_o);
		check_equal(r.name, "link address", r.pc + 2 * INST_BYTES, ex_link_addr_o);
		check_equal(r.name, "instruction", r.inst, ex_inst_o);
		check_equal(r.name, "delay slot", r.delay, ex_in_delay_o);
		check_equal(r.name, "exception", r.exc, ex_exc_code_o);
		check_equal(r.name, "epc", epc, ex_exc_epc_o);
	endtask

	initial begin
		rst_i       = 1'b1;
		pc_i        = '0;
		inst_i      = '0;
		wb_we_i     = 1'b0;
		wb_addr_i   = '0;
		wb_data_i   = '0;
		ex_wdata_i  = '0;
		mem_we_i    = 1'b0;
		mem_waddr_i = '0;
		mem_wdata_i = '0;
		checks      = 0;
		errors      = 0;
		table_ready = 1'b0;
		seed        = 32'h9b8f;
		rf[0]       = '0;
		for (int i = 1; i < REG_COUNT; i++)
			rf[i] = $random(seed);
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_i = 1'b0;
		check_equal("reset", "write enable", 0, ex_we_o);
		check_equal("reset", "unit class", SEL_NOP, ex_alu_sel_o);
		check_equal("reset", "exception", EC_NONE, ex_exc_code_o);
		check_equal("reset", "delay slot", 0, ex_in_delay_o);
		check_equal("reset", "stall", 0, stall_o);
		check_equal("reset", "branch taken", 0, branch_taken_o);

		// Preload through the write-back port
		for (int i = 1; i < REG_COUNT; i++) begin
			wb_we_i   = 1'b1;
			wb_addr_i = reg_addr_t'(i);
			wb_data_i = rf[i];
			@(negedge clk);
		end
		wb_we_i = 1'b0;

		foreach (rows[i])
			apply_row(rows[i]);

		errors = errors + i_dut.i_id_stage_assert.fail_count;
		$display("Rows: %0d, checks: %0d, mismatches: %0d, assertion failures: %0d",
			rows.size(), checks, errors - i_dut.i_id_stage_assert.fail_count,
			i_dut.i_id_stage_assert.fail_count);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog
	initial begin
		wait (table_ready);
		repeat (rows.size() * 20 + RESET_CYCLES + REG_COUNT) @(posedge clk);
		$display("Timeout: the table did not finish in the expected number of cycles");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
mips_isa_pkg.sv
id_ctrl_pkg.sv
reg_file.sv
inst_decoder.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
id_stage_assert.sv
tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - mips_isa_pkg.sv
      - id_ctrl_pkg.sv
      - reg_file.sv
      - inst_decoder.sv
      - operand_forward.sv
      - branch_unit.sv
      - id_stage.sv
  - target: test
    files:
      - id_stage_assert.sv
      - tb_id_stage.sv
